/* design/rp_defs.svh */
////////////////////
// widths and constants shared by the analog
// front end and its system bus fabric
////////////////////
`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

// converter samples
`define RP_ADC_DW      14          // adc and dac code width

// system bus
`define RP_BUS_AW      32
`define RP_BUS_DW      32
`define RP_REGION_LSB  20          // region field, addr[22:20]
`define RP_REGION_MSB  22
`define RP_REGION_N    8

// housekeeping identification word
`define RP_HK_ID       32'h5250_0001

// pwm dac
`define RP_PWM_N       4           // channels
`define RP_PWM_W       8           // duty and counter width

`endif

/* design/rp_pkg.sv */
////////////////////
// sample types and bus encodings
////////////////////
`include "rp_defs.svh"

package rp_pkg;

  // two's complement sample, as seen inside the fabric
  typedef logic signed [`RP_ADC_DW-1:0] sample_t;
  typedef logic signed [`RP_ADC_DW:0]   sample_sum_t;  // one guard bit for the adder

  // address regions, only two carry a block
  typedef enum logic [`RP_REGION_MSB-`RP_REGION_LSB:0] {
    REGION_HK  = 3'd0,
    REGION_AMS = 3'd4
  } sys_region_e;

  // housekeeping word offsets
  typedef enum logic [`RP_REGION_LSB-1:0] {
    HK_ID           = 20'h0_0000,
    HK_DIGITAL_LOOP = 20'h0_0004,
    HK_LED          = 20'h0_0008
  } hk_reg_e;

  // analog register word offsets
  typedef enum logic [`RP_REGION_LSB-1:0] {
    AMS_DC_A = 20'h0_0000,
    AMS_DC_B = 20'h0_0004,
    AMS_FEED = 20'h0_0008,
    AMS_PWM0 = 20'h0_0020,
    AMS_PWM1 = 20'h0_0024,
    AMS_PWM2 = 20'h0_0028,
    AMS_PWM3 = 20'h0_002C
  } ams_reg_e;

endpackage

/* design/sys_bus_decoder.sv */
////////////////////
// system bus decoder, splits the address space
// into eight regions and returns the selected reply
////////////////////
`include "rp_defs.svh"

module sys_bus_decoder
  import rp_pkg::*;
(
  input  logic                                    adc_clk,
  input  logic                                    arst_n_i,
  input  logic [`RP_BUS_AW-1:0]                   sys_addr_i,
  input  logic                                    sys_wen_i,
  input  logic                                    sys_ren_i,
  output logic [`RP_REGION_N-1:0]                 region_wen_o,
  output logic [`RP_REGION_N-1:0]                 region_ren_o,
  input  logic [`RP_REGION_N-1:0][`RP_BUS_DW-1:0] region_rdata_i,
  input  logic [`RP_REGION_N-1:0]                 region_ack_i,
  input  logic [`RP_REGION_N-1:0]                 region_err_i,
  output logic [`RP_BUS_DW-1:0]                   sys_rdata_o,
  output logic                                    sys_ack_o,
  output logic                                    sys_err_o
);

  sys_region_e             region;   // addr[22:20]
  logic [`RP_REGION_N-1:0] sel;      // one-hot
  logic [`RP_REGION_N-1:0] mapped;   // regions with a block behind them
  logic [`RP_REGION_N-1:0] ack_all;  // block acks, unused ones filled in

  assign region = sys_region_e'(sys_addr_i[`RP_REGION_MSB:`RP_REGION_LSB]);
  assign sel    = {{(`RP_REGION_N-1){1'b0}}, 1'b1} << region;

  always_comb
  begin
    mapped             = '0;
    mapped[REGION_HK]  = 1'b1;
    mapped[REGION_AMS] = 1'b1;
  end

  // strobes go only to the addressed region
  assign region_wen_o = sel & {`RP_REGION_N{sys_wen_i}};
  assign region_ren_o = sel & {`RP_REGION_N{sys_ren_i}};

  ////////////////////
  // reply multiplexer
  ////////////////////

  // unused regions ack in the strobe cycle
  assign ack_all = (region_ack_i & mapped) | (~mapped & {`RP_REGION_N{sys_wen_i | sys_ren_i}});

  always_comb
  begin
    sys_rdata_o = '0;  // unused regions read zero
    for (int i = 0; i < `RP_REGION_N; i++)
    begin
      if (sel[i] && mapped[i])
        sys_rdata_o = region_rdata_i[i];
    end
  end

  assign sys_ack_o = |(sel & ack_all);
  assign sys_err_o = |(sel & mapped & region_err_i);

  // master side rules, wen and ren exclusive
  assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    !(sys_wen_i && sys_ren_i))
    else $error("sys_bus_decoder: wen and ren high together");

  // a mapped block answers on the next cycle, address held by the master
  assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    ((sys_wen_i || sys_ren_i) && |(sel & mapped)) |=> sys_ack_o)
    else $error("sys_bus_decoder: mapped region did not ack");

endmodule

/* design/housekeeping_regs.sv */
////////////////////
// housekeeping registers, id word,
// digital loopback switch and leds
////////////////////
`include "rp_defs.svh"

module housekeeping_regs
  import rp_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  arst_n_i,
  input  logic [`RP_BUS_AW-1:0] sys_addr_i,
  input  logic [`RP_BUS_DW-1:0] sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output logic [`RP_BUS_DW-1:0] sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  sys_err_o,
  output logic                  digital_loop_o,
  output logic [8-1:0]          led_o
);

  hk_reg_e reg_ofs;  // word offset inside the region

  assign reg_ofs = hk_reg_e'(sys_addr_i[`RP_REGION_LSB-1:0]);

  // writable registers
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
    end
    else if (sys_wen_i)
    begin
      case (reg_ofs)
        HK_DIGITAL_LOOP: digital_loop_o <= sys_wdata_i[0];
        HK_LED:          led_o          <= sys_wdata_i[7:0];
        default:         ;  // id is read only
      endcase
    end
  end

  // read data, held until the next read
  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
    begin
      case (reg_ofs)
        HK_ID:           sys_rdata_o <= `RP_HK_ID;
        HK_DIGITAL_LOOP: sys_rdata_o <= {{(`RP_BUS_DW-1){1'b0}}, digital_loop_o};
        HK_LED:          sys_rdata_o <= {{(`RP_BUS_DW-8){1'b0}}, led_o};
        default:         sys_rdata_o <= '0;
      endcase
    end
  end

  // one cycle ack
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      sys_ack_o <= 1'b0;
    else
      sys_ack_o <= sys_wen_i | sys_ren_i;
  end

  assign sys_err_o = 1'b0;  // no error source here

  // no ack without a strobe on the cycle before
  assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i))
    else $error("housekeeping_regs: ack without strobe");

endmodule

/* design/ams_regs.sv */
////////////////////
// analog register block, dc levels,
// feedthrough enables and pwm duties
////////////////////
`include "rp_defs.svh"

module ams_regs
  import rp_pkg::*;
(
  input  logic                                adc_clk,
  input  logic                                arst_n_i,
  input  logic [`RP_BUS_AW-1:0]               sys_addr_i,
  input  logic [`RP_BUS_DW-1:0]               sys_wdata_i,
  input  logic                                sys_wen_i,
  input  logic                                sys_ren_i,
  output logic [`RP_BUS_DW-1:0]               sys_rdata_o,
  output logic                                sys_ack_o,
  output logic                                sys_err_o,
  output sample_t                             dc_a_o,
  output sample_t                             dc_b_o,
  output logic [2-1:0]                        feed_en_o,
  output logic [`RP_PWM_N-1:0][`RP_PWM_W-1:0] pwm_duty_o
);

  ams_reg_e reg_ofs;

  assign reg_ofs = ams_reg_e'(sys_addr_i[`RP_REGION_LSB-1:0]);

  ////////////////////
  // write side
  ////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dc_a_o     <= '0;
      dc_b_o     <= '0;
      feed_en_o  <= '0;   // both channels dc only
      pwm_duty_o <= '0;
    end
    else if (sys_wen_i)
    begin
      case (reg_ofs)
        AMS_DC_A: dc_a_o        <= sys_wdata_i[`RP_ADC_DW-1:0];  // low 14 bits
        AMS_DC_B: dc_b_o        <= sys_wdata_i[`RP_ADC_DW-1:0];
        AMS_FEED: feed_en_o     <= sys_wdata_i[1:0];  // bit 0 ch a, bit 1 ch b
        AMS_PWM0: pwm_duty_o[0] <= sys_wdata_i[`RP_PWM_W-1:0];
        AMS_PWM1: pwm_duty_o[1] <= sys_wdata_i[`RP_PWM_W-1:0];
        AMS_PWM2: pwm_duty_o[2] <= sys_wdata_i[`RP_PWM_W-1:0];
        AMS_PWM3: pwm_duty_o[3] <= sys_wdata_i[`RP_PWM_W-1:0];
        default:  ;
      endcase
    end
  end

  ////////////////////
  // read side
  ////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
    begin
      case (reg_ofs)
        // dc levels come back sign extended
        AMS_DC_A: sys_rdata_o <= {{(`RP_BUS_DW-`RP_ADC_DW){dc_a_o[`RP_ADC_DW-1]}}, dc_a_o};
        AMS_DC_B: sys_rdata_o <= {{(`RP_BUS_DW-`RP_ADC_DW){dc_b_o[`RP_ADC_DW-1]}}, dc_b_o};
        AMS_FEED: sys_rdata_o <= {{(`RP_BUS_DW-2){1'b0}}, feed_en_o};
        AMS_PWM0: sys_rdata_o <= {{(`RP_BUS_DW-`RP_PWM_W){1'b0}}, pwm_duty_o[0]};
        AMS_PWM1: sys_rdata_o <= {{(`RP_BUS_DW-`RP_PWM_W){1'b0}}, pwm_duty_o[1]};
        AMS_PWM2: sys_rdata_o <= {{(`RP_BUS_DW-`RP_PWM_W){1'b0}}, pwm_duty_o[2]};
        AMS_PWM3: sys_rdata_o <= {{(`RP_BUS_DW-`RP_PWM_W){1'b0}}, pwm_duty_o[3]};
        default:  sys_rdata_o <= '0;  // hole in the map
      endcase
    end
  end

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      sys_ack_o <= 1'b0;
    else
      sys_ack_o <= sys_wen_i | sys_ren_i;  // ack one cycle after strobe
  end

  assign sys_err_o = 1'b0;

endmodule

/* design/analog_io.sv */
////////////////////
// adc and dac datapath that converts codes
// and sums, saturates and loops back samples
////////////////////
`include "rp_defs.svh"

module analog_io
  import rp_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  arst_n_i,
  input  logic [`RP_ADC_DW-1:0] adc_dat_a_i,
  input  logic [`RP_ADC_DW-1:0] adc_dat_b_i,
  input  logic                  digital_loop_i,
  input  sample_t               dc_a_i,
  input  sample_t               dc_b_i,
  input  logic [2-1:0]          feed_en_i,
  output logic [`RP_ADC_DW-1:0] dac_a_o,
  output logic [`RP_ADC_DW-1:0] dac_b_o
);

  // same bit rule converts in both directions
  function automatic logic [`RP_ADC_DW-1:0] flip_code(input logic [`RP_ADC_DW-1:0] code);
    return {code[`RP_ADC_DW-1], ~code[`RP_ADC_DW-2:0]};
  endfunction

  logic [`RP_ADC_DW-1:0] adc_raw  [2];  // raw codes after the input register
  logic [`RP_ADC_DW-1:0] dac_code [2];  // raw codes in the output register
  sample_t               adc_smp  [2];  // adc or loopback sample
  sample_t               dc_lvl   [2];
  sample_t               fb       [2];  // feedthrough term
  sample_sum_t           sum      [2];
  sample_t               sat      [2];

  assign dc_lvl[0] = dc_a_i;
  assign dc_lvl[1] = dc_b_i;

  // input register
  always_ff @(posedge adc_clk)
  begin
    adc_raw[0] <= adc_dat_a_i;
    adc_raw[1] <= adc_dat_b_i;
  end

  for (genvar ch = 0; ch < 2; ch++)
  begin : g_ch
    // loopback takes the registered dac word
    assign adc_smp[ch] = digital_loop_i ? flip_code(dac_code[ch]) : flip_code(adc_raw[ch]);

    assign fb[ch]  = feed_en_i[ch] ? adc_smp[ch] : '0;
    assign sum[ch] = sample_sum_t'(dc_lvl[ch]) + sample_sum_t'(fb[ch]);  // sign extended

    // clamp when the two top bits disagree
    assign sat[ch] = (sum[ch][`RP_ADC_DW] ^ sum[ch][`RP_ADC_DW-1])
                   ? {sum[ch][`RP_ADC_DW], {(`RP_ADC_DW-1){~sum[ch][`RP_ADC_DW]}}}
                   : sum[ch][`RP_ADC_DW-1:0];

    // out of range sums end up on a full-scale output code
    assert property (@(posedge adc_clk) disable iff (!arst_n_i)
      ((sum[ch] > sample_sum_t'((2 ** (`RP_ADC_DW - 1)) - 1))
        || (sum[ch] < sample_sum_t'(-(2 ** (`RP_ADC_DW - 1)))))
      |=> (dac_code[ch] == {`RP_ADC_DW{$past(sum[ch][`RP_ADC_DW])}}))
      else $error("analog_io: ch %0d saturation miss", ch);
  end

  ////////////////////
  // dac output register
  ////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_code[0] <= {1'b0, {(`RP_ADC_DW-1){1'b1}}};  // code of sample zero
      dac_code[1] <= {1'b0, {(`RP_ADC_DW-1){1'b1}}};
    end
    else
    begin
      dac_code[0] <= flip_code(sat[0]);
      dac_code[1] <= flip_code(sat[1]);
    end
  end

  assign dac_a_o = dac_code[0];
  assign dac_b_o = dac_code[1];

endmodule

/* design/pwm_dac.sv */
////////////////////
// four channel pwm dac on one shared counter
////////////////////
`include "rp_defs.svh"

module pwm_dac
  import rp_pkg::*;
(
  input  logic                                adc_clk,
  input  logic                                arst_n_i,
  input  logic [`RP_PWM_N-1:0][`RP_PWM_W-1:0] duty_i,
  output logic [`RP_PWM_N-1:0]                pwm_o
);

  logic [`RP_PWM_W-1:0] cnt;  // free running over 256 cycles

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      cnt <= '0;
    else
      cnt <= cnt + 1'b1;  // wraps
  end

  // registered compare per channel
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      pwm_o <= '0;
    else
    begin
      for (int i = 0; i < `RP_PWM_N; i++)
      begin
        pwm_o[i] <= (cnt < duty_i[i]);  // high for duty counts
      end
    end
  end

  for (genvar i = 0; i < `RP_PWM_N; i++)
  begin : g_chk
    // zero duty never produces a pulse
    assert property (@(posedge adc_clk) disable iff (!arst_n_i)
      (duty_i[i] == '0) |=> !pwm_o[i])
      else $error("pwm_dac: ch %0d high at zero duty", i);
  end

endmodule

/* design/rp_top.sv */
////////////////////
// top level, bus decoder, register blocks,
// analog datapath and pwm outputs
////////////////////
`include "rp_defs.svh"

module rp_top (
  input  logic                  adc_clk,
  input  logic                  arst_n_i,
  // system bus
  input  logic [`RP_BUS_AW-1:0] sys_addr_i,
  input  logic [`RP_BUS_DW-1:0] sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output logic [`RP_BUS_DW-1:0] sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  sys_err_o,
  // converters
  input  logic [`RP_ADC_DW-1:0] adc_dat_a_i,
  input  logic [`RP_ADC_DW-1:0] adc_dat_b_i,
  output logic [`RP_ADC_DW-1:0] dac_a_o,
  output logic [`RP_ADC_DW-1:0] dac_b_o,
  output logic [`RP_PWM_N-1:0]  pwm_o,
  output logic [8-1:0]          led_o
);

  logic [`RP_REGION_N-1:0]             region_wen;
  logic [`RP_REGION_N-1:0]             region_ren;
  logic [`RP_BUS_DW-1:0]               hk_rdata;
  logic [`RP_BUS_DW-1:0]               ams_rdata;
  logic                                hk_ack;
  logic                                ams_ack;
  logic                                hk_err;
  logic                                ams_err;
  logic                                digital_loop;
  logic signed [`RP_ADC_DW-1:0]        dc_a;
  logic signed [`RP_ADC_DW-1:0]        dc_b;
  logic [2-1:0]                        feed_en;
  logic [`RP_PWM_N-1:0][`RP_PWM_W-1:0] pwm_duty;

  ////////////////////
  // bus fabric
  ////////////////////

  // hk sits in region 0, ams in region 4, the rest is empty
  sys_bus_decoder u_dec (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .sys_addr_i     (sys_addr_i),
    .sys_wen_i      (sys_wen_i),
    .sys_ren_i      (sys_ren_i),
    .region_wen_o   (region_wen),
    .region_ren_o   (region_ren),
    .region_rdata_i ({{(3*`RP_BUS_DW){1'b0}}, ams_rdata, {(3*`RP_BUS_DW){1'b0}}, hk_rdata}),
    .region_ack_i   ({3'b000, ams_ack, 3'b000, hk_ack}),
    .region_err_i   ({3'b000, ams_err, 3'b000, hk_err}),
    .sys_rdata_o    (sys_rdata_o),
    .sys_ack_o      (sys_ack_o),
    .sys_err_o      (sys_err_o)
  );

  housekeeping_regs u_hk (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_wen_i      (region_wen[0]),
    .sys_ren_i      (region_ren[0]),
    .sys_rdata_o    (hk_rdata),
    .sys_ack_o      (hk_ack),
    .sys_err_o      (hk_err),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  ams_regs u_ams (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (region_wen[4]),
    .sys_ren_i   (region_ren[4]),
    .sys_rdata_o (ams_rdata),
    .sys_ack_o   (ams_ack),
    .sys_err_o   (ams_err),
    .dc_a_o      (dc_a),
    .dc_b_o      (dc_b),
    .feed_en_o   (feed_en),
    .pwm_duty_o  (pwm_duty)
  );

  ////////////////////
  // signal path
  ////////////////////

  analog_io u_aio (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .dc_a_i         (dc_a),
    .dc_b_i         (dc_b),
    .feed_en_i      (feed_en),
    .dac_a_o        (dac_a_o),
    .dac_b_o        (dac_b_o)
  );

  pwm_dac u_pwm (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .duty_i   (pwm_duty),
    .pwm_o    (pwm_o)
  );

endmodule

/* tb/tb_top.sv */
////////////////////
// testbench for the analog front end top
// with bus access, datapath and pwm checks
////////////////////
`include "rp_defs.svh"

module tb_top
  import rp_pkg::*;
();

  typedef logic [`RP_ADC_DW-1:0] code_t;

  localparam int FS_MAX   = 2 ** (`RP_ADC_DW - 1) - 1;
  localparam int FS_MIN   = -(2 ** (`RP_ADC_DW - 1));
  localparam int BUS_TMO  = 32;     // cycles to wait for an ack
  localparam int LOOP_TMO = 20000;  // worst case ramp through the loopback
  localparam logic [31:0] HK_BASE  = 32'h0000_0000;
  localparam logic [31:0] AMS_BASE = 32'h0040_0000;
  localparam logic [31:0] NUL_BASE = 32'h0050_0000;  // region 5 has no block

  logic                  adc_clk;
  logic                  arst_n_i;
  logic [`RP_BUS_AW-1:0] sys_addr_i;
  logic [`RP_BUS_DW-1:0] sys_wdata_i;
  logic                  sys_wen_i;
  logic                  sys_ren_i;
  logic [`RP_BUS_DW-1:0] sys_rdata_o;
  logic                  sys_ack_o;
  logic                  sys_err_o;
  logic [`RP_ADC_DW-1:0] adc_dat_a_i;
  logic [`RP_ADC_DW-1:0] adc_dat_b_i;
  logic [`RP_ADC_DW-1:0] dac_a_o;
  logic [`RP_ADC_DW-1:0] dac_b_o;
  logic [`RP_PWM_N-1:0]  pwm_o;
  logic [8-1:0]          led_o;

  int       n_checks;
  int       n_errors;
  int       test_errors;  // error count at the end of the last test
  logic     hung;         // a wait loop ran out
  ams_reg_e ams_list [7];

  rp_top u_dut (.*);

  initial adc_clk = 1'b0;
  always #5 adc_clk = ~adc_clk;

  // err never rises in this fabric
  assert property (@(posedge adc_clk) disable iff (!arst_n_i) !sys_err_o)
  else
  begin
    n_errors++;
    $display("[ERROR] sys_err_o got 0x1 expected 0x0");
  end

  initial
  begin
    wait (hung);
    $display("Checks failed");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    assert (got === exp)
    else
    begin
      n_errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s done, %0d errors", name, n_errors - test_errors);
    test_errors = n_errors;
  endtask

  ////////////////////
  // bus master
  ////////////////////

  // entered right after a falling edge with a single cycle strobe
  task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int   cnt;
    logic got_ack;
    logic err_seen;
    cnt         = 0;
    got_ack     = 1'b0;
    err_seen    = 1'b0;
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = !wr;
    while (!got_ack && cnt < BUS_TMO)
    begin
      @(negedge adc_clk);
      got_ack   = sys_ack_o;  // sampled before the strobe drops
      err_seen  = sys_err_o;
      rdata     = sys_rdata_o;
      sys_wen_i = 1'b0;
      sys_ren_i = 1'b0;
      cnt++;
    end
    if (!got_ack)
    begin
      $display("bus access to 0x%08h got no ack within %0d cycles", addr, BUS_TMO);
      hung = 1'b1;
      @(posedge adc_clk);
    end
    else
    begin
      check_value("sys_err_o", 32'(err_seen), 32'h0);
      @(negedge adc_clk);  // address held one more cycle
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused_rd;
    bus_access(1'b1, addr, data, unused_rd);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(1'b0, addr, 32'h0, data);
  endtask

  task automatic set_path(input int dc_a, input int dc_b, input logic [1:0] feed);
    bus_write(AMS_BASE | 32'(AMS_DC_A), 32'(dc_a));
    bus_write(AMS_BASE | 32'(AMS_DC_B), 32'(dc_b));
    bus_write(AMS_BASE | 32'(AMS_FEED), 32'(feed));
  endtask

  ////////////////////
  // datapath model
  ////////////////////

  // in negative slope code 0 is positive full scale
  function automatic code_t predict_dac(input code_t code, input int dc, input bit feed);
    int smp;
    int total;
    smp   = feed ? FS_MAX - int'(code) : 0;
    total = dc + smp;
    if (total > FS_MAX)
      total = FS_MAX;
    else if (total < FS_MIN)
      total = FS_MIN;
    return code_t'(FS_MAX - total);
  endfunction

  function automatic code_t pick_code(input bit extremes);
    code_t edge_codes [4];
    edge_codes = '{14'h0000, 14'h1FFF, 14'h2000, 14'h3FFF};
    if (extremes && $urandom_range(1) == 1)
      return edge_codes[$urandom_range(3)];
    return code_t'($urandom);
  endfunction

  // new sample each cycle and the dac compared with the one from two cycles back
  task automatic stream_check(input int n, input bit extremes, input int dc_a, input int dc_b,
                              input logic [1:0] feed, input bit identity);
    code_t hist_a [2];
    code_t hist_b [2];
    for (int i = 0; i < n + 2; i++)
    begin
      if (i >= 2)
      begin
        check_value("dac_a_o", 32'(dac_a_o),
                    identity ? 32'(hist_a[1]) : 32'(predict_dac(hist_a[1], dc_a, feed[0])));
        check_value("dac_b_o", 32'(dac_b_o),
                    identity ? 32'(hist_b[1]) : 32'(predict_dac(hist_b[1], dc_b, feed[1])));
      end
      hist_a[1]   = hist_a[0];
      hist_b[1]   = hist_b[0];
      hist_a[0]   = pick_code(extremes);
      hist_b[0]   = pick_code(extremes);
      adc_dat_a_i = hist_a[0];
      adc_dat_b_i = hist_b[0];
      @(negedge adc_clk);
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial
  begin
    int              cnt;
    int              dc_a;
    int              dc_b;
    int              hi [`RP_PWM_N];
    logic [7:0]      duty [`RP_PWM_N];
    logic [1:0]      feed;
    logic [7:0]      led_val;
    logic [31:0]     wr_word;
    logic [31:0]     rd_word;
    logic [31:0]     exp_word;
    void'($urandom(32'h2502_552b));
    n_checks    = 0;
    n_errors    = 0;
    test_errors = 0;
    hung        = 1'b0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    adc_dat_a_i = 14'h1FFF;
    adc_dat_b_i = 14'h1FFF;
    ams_list    = '{AMS_DC_A, AMS_DC_B, AMS_FEED, AMS_PWM0, AMS_PWM1, AMS_PWM2, AMS_PWM3};
    arst_n_i    = 1'b0;
    repeat (10) @(negedge adc_clk);
    arst_n_i = 1'b1;
    @(negedge adc_clk);

    // id word and empty region after reset
    check_value("dac_a_o", 32'(dac_a_o), 32'h1FFF);
    check_value("led_o", 32'(led_o), 32'h0);
    bus_read(HK_BASE | 32'(HK_ID), rd_word);
    check_value("hk id rdata", rd_word, `RP_HK_ID);
    bus_read(NUL_BASE, rd_word);
    check_value("region 5 rdata", rd_word, 32'h0);
    finish_test("bus_id");

    // led register and ams readback
    led_val = 8'($urandom);
    bus_write(HK_BASE | 32'(HK_LED), 32'(led_val));
    check_value("led_o", 32'(led_o), 32'(led_val));
    foreach (ams_list[k])
    begin
      wr_word = $urandom;
      bus_write(AMS_BASE | 32'(ams_list[k]), wr_word);
      bus_read(AMS_BASE | 32'(ams_list[k]), rd_word);
      case (ams_list[k])
        AMS_DC_A, AMS_DC_B: exp_word = {{(`RP_BUS_DW-`RP_ADC_DW){wr_word[13]}}, wr_word[13:0]};
        AMS_FEED:           exp_word = {30'd0, wr_word[1:0]};
        default:            exp_word = {24'd0, wr_word[7:0]};
      endcase
      check_value($sformatf("ams rdata at 0x%02h", ams_list[k]), rd_word, exp_word);
    end
    bus_read(AMS_BASE | 32'h10, rd_word);  // hole in the map
    check_value("ams unmapped rdata", rd_word, 32'h0);
    finish_test("registers");

    // conversions cancel with zero dc
    set_path(0, 0, 2'b11);
    stream_check(64, 1'b0, 0, 0, 2'b11, 1'b1);
    finish_test("feedthrough");

    // first two rounds force saturation at both ends
    for (int r = 0; r < 6; r++)
    begin
      dc_a = (r == 0) ? FS_MAX : (r == 1) ? FS_MIN : int'($urandom_range(16383)) - 8192;
      dc_b = (r == 0) ? FS_MIN : (r == 1) ? FS_MAX : int'($urandom_range(16383)) - 8192;
      feed = (r < 2) ? 2'b11 : 2'($urandom_range(3));
      set_path(dc_a, dc_b, feed);
      stream_check(40, 1'b1, dc_a, dc_b, feed, 1'b0);
    end
    finish_test("sum_saturation");

    // loopback ramps up by dc each cycle
    adc_dat_a_i = 14'h1FFF;  // sample zero so the ramp starts below full scale
    dc_a = 1 + int'($urandom_range(255));
    set_path(dc_a, 0, 2'b11);
    bus_write(HK_BASE | 32'(HK_DIGITAL_LOOP), 32'h1);
    cnt = 0;
    while (dac_a_o !== 14'h0000 && cnt < LOOP_TMO)
    begin
      @(negedge adc_clk);
      cnt++;
    end
    if (dac_a_o !== 14'h0000)
    begin
      $display("dac_a_o did not reach full scale within %0d cycles", LOOP_TMO);
      hung = 1'b1;
      @(posedge adc_clk);
    end
    repeat (50)
    begin
      check_value("dac_a_o", 32'(dac_a_o), 32'h0);
      @(negedge adc_clk);
    end
    bus_write(HK_BASE | 32'(HK_DIGITAL_LOOP), 32'h0);
    finish_test("loopback");

    // random pwm duties with the last channel at zero
    for (int ch = 0; ch < `RP_PWM_N; ch++)
    begin
      duty[ch] = (ch == `RP_PWM_N - 1) ? 8'h00 : 8'(1 + $urandom_range(254));
      hi[ch]   = 0;
      bus_write(AMS_BASE + 32'(AMS_PWM0) + 32'(4 * ch), 32'(duty[ch]));
    end
    repeat (4) @(negedge adc_clk);
    for (int c = 0; c < 256; c++)
    begin
      for (int ch = 0; ch < `RP_PWM_N; ch++)
        hi[ch] += int'(pwm_o[ch]);
      @(negedge adc_clk);
    end
    for (int ch = 0; ch < `RP_PWM_N; ch++)
      check_value($sformatf("pwm_o[%0d] high cycles", ch), 32'(hi[ch]), 32'(duty[ch]));
    finish_test("pwm");

    $display("summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

/* compile.f */
+incdir+design
design/rp_pkg.sv
design/sys_bus_decoder.sv
design/housekeeping_regs.sv
design/ams_regs.sv
design/analog_io.sv
design/pwm_dac.sv
design/rp_top.sv
tb/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_top -Mdir obj_dir -o tb_sim \
  && ./obj_dir/tb_sim 2>&1 | tee sim.log
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
